//--- tb.f
+incdir+tb
rtl/sched_pkg.sv
rtl/sched_oh_mux.sv
rtl/sched_age_pick.sv
rtl/sched_entry.sv
rtl/sched_ring_ptr.sv
rtl/sched_issue_queue.sv
tb/tb_sched_issue_queue.sv

//--- tb/tb_sched_checks.svh
`ifndef TB_SCHED_CHECKS_SVH
`define TB_SCHED_CHECKS_SVH

// One scenario with two ops, wakeup timing, pipe behavior and expected issue order
typedef struct {
  disp_t               op0;
  disp_t               op1;
  logic [1:0]          vld;
  int                  wake_dly;   // 0 means no wakeup driven
  logic [TAG_W-1:0]    wake_tag;
  logic                conflict;   // Bounce the first issue once
  logic                flush;      // Flush in the cycle after dispatch
  int                  exp_n;
  logic [CMT_ID_W-1:0] exp [3];
} row_t;

task automatic check_issue(input issue_t got, input issue_t exp);
  if (got !== exp) begin
    $display("error: o_issue got %h exp %h", got, exp);
    err_cnt++;
  end
endtask

task automatic check_index(input logic [ENTRY_NUM-1:0] got,
                           input logic [ENTRY_NUM-1:0] exp);
  if (got !== exp) begin
    $display("error: o_iss_index_oh got %h exp %h", got, exp);
    err_cnt++;
  end
endtask

task automatic check_done(input done_rpt_t got, input done_rpt_t exp);
  if (got !== exp) begin
    $display("error: o_done_rpt got %h exp %h", got, exp);
    err_cnt++;
  end
endtask

task automatic check_cre(input cre_ret_t got, input cre_ret_t exp);
  if (got !== exp) begin
    $display("error: o_cre_ret got %h exp %h", got, exp);
    err_cnt++;
  end
endtask

task automatic check_flag(input logic ok, input string what);
  if (ok !== 1'b1) begin
    $display("check failed: %s", what);
    err_cnt++;
  end
endtask

function automatic logic [31:0] xorshift(input logic [31:0] x);
  x = x ^ (x << 13);
  x = x ^ (x >> 17);
  x = x ^ (x << 5);
  return x;
endfunction

`endif

//--- tb/tb_sched_issue_queue.sv
`timescale 1ns/1ps
`default_nettype none

module tb_sched_issue_queue
  import sched_pkg::*;
;
  localparam int N_ROWS = 12;

  logic                  i_clk;
  logic                  i_reset_n;
  logic [DISP_PORTS-1:0] i_disp_valid;
  disp_t                 i_disp [DISP_PORTS];
  wakeup_t               i_wakeup [WAKE_PORTS];
  issue_t                o_issue;
  logic [ENTRY_NUM-1:0]  o_iss_index_oh;
  logic                  i_rs_conflict;
  logic [ENTRY_NUM-1:0]  i_rs_conf_index_oh;
  logic                  i_pipe_done;
  logic [ENTRY_NUM-1:0]  i_pipe_done_index_oh;
  done_rpt_t             o_done_rpt;
  cre_ret_t              o_cre_ret;
  logic                  i_flush;

  int          err_cnt = 0;
  int          credits = ENTRY_NUM;  // Dispatcher side
  int          occ     = 0;          // Slots held in the queue
  int          in_slot = 0;          // Where the next port 0 op lands
  logic [31:0] rng     = 32'h9d86;

  `include "tb_sched_checks.svh"

  row_t        rows [N_ROWS];

  sched_issue_queue i_dut (.*);

  always #10 i_clk = ~i_clk;

  function automatic disp_t mk_op(input int cmt, input int rs1, input logic r1,
                                  input int rs2, input logic r2);
    disp_t d;
    d = '{cmt_id: CMT_ID_W'(cmt), opcode: 8'(8'h40 + cmt), rd_tag: TAG_W'(cmt + 32),
          rs1_tag: TAG_W'(rs1), rs1_ready: r1, rs2_tag: TAG_W'(rs2), rs2_ready: r2};
    return d;
  endfunction

  task automatic add_row(input int i, input disp_t a, input disp_t b, input logic [1:0] v,
                         input int wk, input int tag, input logic cf, input logic fl,
                         input int n, input int e0, input int e1, input int e2);
    rows[i] = '{op0: a, op1: b, vld: v, wake_dly: wk, wake_tag: TAG_W'(tag), conflict: cf,
                flush: fl, exp_n: n,
                exp: '{CMT_ID_W'(e0), CMT_ID_W'(e1), CMT_ID_W'(e2)}};
  endtask

  // Expected pipe op built from the dispatched fields
  function automatic issue_t exp_issue(input row_t r, input logic [CMT_ID_W-1:0] cmt);
    disp_t  d;
    issue_t e;
    d = (r.op0.cmt_id == cmt) ? r.op0 : r.op1;
    e = '{valid: 1'b1, cmt_id: d.cmt_id, opcode: d.opcode, rd_tag: d.rd_tag,
          rs1_tag: d.rs1_tag, rs2_tag: d.rs2_tag};
    return e;
  endfunction

  task automatic idle_inputs();
    i_disp_valid         = '0;
    i_rs_conflict        = 1'b0;
    i_rs_conf_index_oh   = '0;
    i_pipe_done          = 1'b0;
    i_pipe_done_index_oh = '0;
    i_flush              = 1'b0;
    for (int p = 0; p < WAKE_PORTS; p++) i_wakeup[p] = '0;
  endtask

  //------------------------------
  task automatic run_row(input int ri);
    row_t                 r;
    int                   cyc;
    int                   n_iss;
    int                   first_iss;
    int                   flush_extra;
    int                   err0;
    int                   conf_cyc;
    int                   k;
    int                   base;
    int                   slot;
    logic                 bounced;
    logic [ENTRY_NUM-1:0] conf_oh;
    logic [CMT_ID_W-1:0]  iss_cmt;
    done_rpt_t            exp_done;
    done_rpt_t            next_done;
    int                   due_q [$];
    logic [ENTRY_NUM-1:0] oh_q [$];
    logic [CMT_ID_W-1:0]  cmt_q [$];
    r = rows[ri];
    err0 = err_cnt;
    n_iss = 0;
    first_iss = -1;
    flush_extra = 0;
    bounced = 1'b0;
    conf_cyc = -1;
    conf_oh = '0;
    exp_done = '0;
    base = in_slot;
    for (cyc = 0; cyc < 30; cyc++) begin
      @(posedge i_clk);
      #2;
      idle_inputs();
      next_done = '0;
      if (cyc == 0 || (r.flush && cyc == 1)) begin
        i_disp_valid = r.vld;
        i_disp[0] = r.op0;
        i_disp[1] = r.op1;
        credits -= $countones(r.vld);
        check_flag(credits >= 0, "dispatcher credits went negative");
        if (cyc == 0) begin
          occ += $countones(r.vld);
          in_slot = (in_slot + $countones(r.vld)) % ENTRY_NUM;
        end else begin
          flush_extra = $countones(r.vld);
        end
      end
      if (r.flush && cyc == 1) i_flush = 1'b1;
      if (r.wake_dly != 0 && cyc == r.wake_dly) i_wakeup[0] = '{valid: 1'b1, tag: r.wake_tag};
      if (cyc == conf_cyc) begin
        i_rs_conflict = 1'b1;
        i_rs_conf_index_oh = conf_oh;
      end
      k = -1;
      foreach (due_q[j]) begin
        if (k < 0 && due_q[j] <= cyc) k = j;
      end
      if (k >= 0) begin
        i_pipe_done = 1'b1;
        i_pipe_done_index_oh = oh_q[k];
        next_done = '{valid: 1'b1, cmt_id: cmt_q[k]};
        due_q.delete(k);
        oh_q.delete(k);
        cmt_q.delete(k);
      end
      @(negedge i_clk);
      check_done(o_done_rpt, exp_done);
      exp_done = next_done;
      if (o_issue.valid) begin
        iss_cmt = '0;
        if (n_iss >= r.exp_n) begin
          $display("unexpected issue of op %h in row %0d", o_issue.cmt_id, ri);
          err_cnt++;
        end else begin
          iss_cmt = r.exp[n_iss];
          slot = (iss_cmt == r.op0.cmt_id) ? base : (base + 1) % ENTRY_NUM;
          check_issue(o_issue, exp_issue(r, iss_cmt));
          check_index(o_iss_index_oh, ENTRY_NUM'(1) << slot);
        end
        if (first_iss < 0) first_iss = cyc;
        if (r.wake_dly != 0 && o_issue.cmt_id == r.op0.cmt_id)
          check_flag(cyc > r.wake_dly, "op issued before its wakeup landed");
        if (r.wake_dly == 0 && r.vld == 2'b11)
          check_flag(cyc == n_iss + 1, "paired ops did not issue on consecutive cycles");
        n_iss++;
        if (r.conflict && !bounced) begin
          bounced = 1'b1;
          conf_cyc = cyc + 1;
          conf_oh = o_iss_index_oh;
        end else begin
          rng = xorshift(rng);
          due_q.push_back(cyc + 1 + int'(rng % 4));
          oh_q.push_back(o_iss_index_oh);
          cmt_q.push_back(iss_cmt);
        end
      end
      if (r.flush && cyc == 2) begin
        check_cre(o_cre_ret, '{valid: 1'b1, count: CNT_W'(occ + flush_extra)});
        occ += flush_extra;
      end
      if (o_cre_ret.valid) begin
        credits += o_cre_ret.count;
        occ -= o_cre_ret.count;
        check_flag(occ >= 0 && credits <= ENTRY_NUM, "credit return exceeds dispatch");
      end
      if (cyc >= 5 && n_iss == r.exp_n && due_q.size() == 0 && occ == 0 && !exp_done.valid)
        break;
    end
    check_flag(cyc < 30, "row did not drain in time");
    check_flag(n_iss == r.exp_n, "issue count differs from expected");
    check_flag(credits == ENTRY_NUM, "credits not all returned");
    if (r.wake_dly == 0 && !r.flush)
      check_flag(first_iss == 1, "first issue not in the cycle after dispatch");
    $display("row %0d: %s", ri, (err_cnt == err0) ? "ok" : "FAIL");
  endtask

  //------------------------------
  initial begin
    i_clk = 1'b0;
    i_reset_n = 1'b1;  // Reset level is high
    i_disp[0] = '0;
    i_disp[1] = '0;
    idle_inputs();
    add_row(0,  mk_op(1, 1, 1, 2, 1),   mk_op(2, 3, 1, 4, 1),  2'b11, 0, 0,  0, 0, 2, 1, 2, 0);
    add_row(1,  mk_op(3, 5, 1, 6, 1),   '0,                    2'b01, 0, 0,  0, 0, 1, 3, 0, 0);
    add_row(2,  mk_op(4, 20, 0, 7, 1),  mk_op(5, 8, 1, 9, 1),  2'b11, 3, 20, 0, 0, 2, 5, 4, 0);
    add_row(3,  mk_op(6, 1, 1, 2, 1),   mk_op(7, 3, 1, 4, 1),  2'b11, 0, 0,  1, 0, 3, 6, 7, 6);
    add_row(4,  mk_op(8, 5, 1, 6, 1),   '0,                    2'b01, 0, 0,  1, 0, 2, 8, 8, 0);
    add_row(5,  mk_op(9, 21, 0, 1, 1),  mk_op(10, 21, 0, 2, 1), 2'b11, 2, 21, 0, 0, 2, 9, 10, 0);
    add_row(6,  mk_op(11, 30, 0, 1, 1), mk_op(12, 30, 0, 2, 1), 2'b11, 3, 30, 0, 1, 0, 0, 0, 0);
    add_row(7,  mk_op(13, 1, 1, 2, 1),  mk_op(14, 3, 1, 4, 1), 2'b11, 0, 0,  0, 0, 2, 13, 14, 0);
    add_row(8,  mk_op(15, 1, 1, 22, 0), '0,                    2'b01, 1, 22, 0, 0, 1, 15, 0, 0);
    add_row(9,  mk_op(16, 1, 1, 2, 1),  mk_op(17, 3, 1, 4, 1), 2'b11, 0, 0,  1, 0, 3, 16, 17, 16);
    add_row(10, mk_op(18, 23, 0, 2, 1), mk_op(19, 3, 1, 4, 1), 2'b11, 4, 23, 0, 0, 2, 19, 18, 0);
    add_row(11, mk_op(20, 5, 1, 6, 1),  mk_op(21, 7, 1, 8, 1), 2'b11, 0, 0,  0, 0, 2, 20, 21, 0);
    repeat (5) @(posedge i_clk);
    #2 i_reset_n = 1'b0;
    @(negedge i_clk);
    check_flag(!o_issue.valid && !o_done_rpt.valid && !o_cre_ret.valid,
               "outputs active after reset");
    for (int ri = 0; ri < N_ROWS; ri++) run_row(ri);
    $display("rows %0d, errors %0d", N_ROWS, err_cnt);
    if (err_cnt == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  // Watchdog sized at 40 cycles per row plus reset
  initial begin
    #((N_ROWS * 40 + 10) * 20);
    $display("timeout: run did not finish");
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

//--- rtl/sched_issue_queue.sv
`timescale 1ns/1ps
`default_nettype none

module sched_issue_queue
  import sched_pkg::*;
(
  input  logic                  i_clk,
  input  logic                  i_reset_n,

  input  logic [DISP_PORTS-1:0] i_disp_valid,
  input  disp_t                 i_disp [DISP_PORTS],

  input  wakeup_t               i_wakeup [WAKE_PORTS],

  output issue_t                o_issue,
  output logic [ENTRY_NUM-1:0]  o_iss_index_oh,

  input  logic                  i_rs_conflict,
  input  logic [ENTRY_NUM-1:0]  i_rs_conf_index_oh,
  input  logic                  i_pipe_done,
  input  logic [ENTRY_NUM-1:0]  i_pipe_done_index_oh,

  output done_rpt_t             o_done_rpt,
  output cre_ret_t              o_cre_ret,

  input  logic                  i_flush
);

  logic [PTR_W-1:0]     w_in_ptr;
  logic [PTR_W-1:0]     w_out_ptr;

  logic [ENTRY_NUM-1:0] w_entry_valid;
  logic [ENTRY_NUM-1:0] w_entry_ready;
  logic [ENTRY_NUM-1:0] w_entry_done;
  logic [ENTRY_NUM-1:0] w_pick_oh;
  issue_t               w_entry [ENTRY_NUM];
  logic [CMT_ID_W-1:0]  w_entry_cmt_id [ENTRY_NUM];
  logic [CMT_ID_W-1:0]  w_done_cmt_id;

  sched_ring_ptr u_ring_ptr (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_disp_valid  (i_disp_valid),
    .i_entry_valid (w_entry_valid),
    .i_flush       (i_flush),
    .o_in_ptr      (w_in_ptr),
    .o_out_ptr     (w_out_ptr),
    .o_cre_ret     (o_cre_ret)
  );

  // ----------------------------
  // Entry array
  // ----------------------------
  for (genvar s = 0; s < ENTRY_NUM; s++) begin : g_slot
    logic [DISP_PORTS-1:0] w_put_sel;
    disp_t                 w_put_data;

    // Port p lands at in_ptr + p
    for (genvar p = 0; p < DISP_PORTS; p++) begin : g_port
      logic [PTR_W-1:0] w_target;
      assign w_target     = w_in_ptr + PTR_W'(p);
      assign w_put_sel[p] = i_disp_valid[p] & ~i_flush & (w_target == PTR_W'(s));
    end

    sched_oh_mux #(
      .T     (disp_t),
      .WORDS (DISP_PORTS)
    ) u_put_mux (
      .i_oh       (w_put_sel),
      .i_data     (i_disp),
      .o_selected (w_put_data)
    );

    sched_entry u_entry (
      .i_clk         (i_clk),
      .i_reset_n     (i_reset_n),
      .i_put         (|w_put_sel),
      .i_put_data    (w_put_data),
      .i_wakeup      (i_wakeup),
      .i_picked      (w_pick_oh[s]),
      .i_rs_conflict (i_rs_conflict & i_rs_conf_index_oh[s]),
      .i_pipe_done   (i_pipe_done & i_pipe_done_index_oh[s]),
      .i_flush       (i_flush),
      .o_valid       (w_entry_valid[s]),
      .o_ready       (w_entry_ready[s]),
      .o_done        (w_entry_done[s]),
      .o_entry       (w_entry[s]),
      .o_cmt_id      (w_entry_cmt_id[s])
    );
  end

  // ----------------------------
  // Issue select
  // ----------------------------
  sched_age_pick u_age_pick (
    .i_ready   (w_entry_ready),
    .i_out_ptr (w_out_ptr),
    .o_pick_oh (w_pick_oh)
  );

  sched_oh_mux #(
    .T     (issue_t),
    .WORDS (ENTRY_NUM)
  ) u_issue_mux (
    .i_oh       (w_pick_oh),
    .i_data     (w_entry),
    .o_selected (o_issue)
  );

  assign o_iss_index_oh = w_pick_oh;

  // ----------------------------
  // Done report
  // ----------------------------
  sched_oh_mux #(
    .T     (logic [CMT_ID_W-1:0]),
    .WORDS (ENTRY_NUM)
  ) u_done_mux (
    .i_oh       (w_entry_done),
    .i_data     (w_entry_cmt_id),
    .o_selected (w_done_cmt_id)
  );

  assign o_done_rpt.valid  = |w_entry_done;
  assign o_done_rpt.cmt_id = w_done_cmt_id;

  // Pipe completion always reaches the report one cycle on
  a_done_follows: assert property (@(posedge i_clk) disable iff (i_reset_n)
    (i_pipe_done && !i_flush) |=> o_done_rpt.valid)
    else $error("sched_issue_queue: pipe done without done report");

endmodule

`default_nettype wire

//--- rtl/sched_ring_ptr.sv
`timescale 1ns/1ps
`default_nettype none

module sched_ring_ptr
  import sched_pkg::*;
(
  input  logic                  i_clk,
  input  logic                  i_reset_n,

  input  logic [DISP_PORTS-1:0] i_disp_valid,
  input  logic [ENTRY_NUM-1:0]  i_entry_valid,
  input  logic                  i_flush,

  output logic [PTR_W-1:0]      o_in_ptr,
  output logic [PTR_W-1:0]      o_out_ptr,
  output cre_ret_t              o_cre_ret
);

  logic [PTR_W-1:0]     r_in_ptr;
  logic [PTR_W-1:0]     r_out_ptr;
  logic [CNT_W-1:0]     r_occ;       // Slots between out and in
  cre_ret_t             r_cre_ret;

  logic [CNT_W-1:0]     w_disp_cnt;
  logic [CNT_W-1:0]     w_free_cnt;
  logic [ENTRY_NUM-1:0] w_span_mask;

  always_comb begin
    w_disp_cnt = '0;
    for (int p = 0; p < DISP_PORTS; p++) begin
      w_disp_cnt = w_disp_cnt + CNT_W'(i_disp_valid[p]);
    end
  end

  // ----------------------------
  // Walk freed slots from out
  // ----------------------------
  always_comb begin : walk
    logic             run;
    logic [PTR_W-1:0] idx;
    run         = 1'b1;
    w_free_cnt  = '0;
    w_span_mask = '0;
    for (int k = 0; k < ENTRY_NUM; k++) begin
      idx = r_out_ptr + PTR_W'(k);
      if (CNT_W'(k) < r_occ) begin
        w_span_mask[idx] = 1'b1;
        if (run && !i_entry_valid[idx]) begin
          w_free_cnt = w_free_cnt + CNT_W'(1);
        end else begin
          run = 1'b0;  // First live slot ends the walk
        end
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_reset_n) begin
      r_in_ptr  <= '0;
      r_out_ptr <= '0;
      r_occ     <= '0;
      r_cre_ret <= '0;
    end else if (i_flush) begin
      // Everything back, plus the dispatch dropped this cycle
      r_out_ptr       <= r_in_ptr;
      r_occ           <= '0;
      r_cre_ret.valid <= (r_occ + w_disp_cnt) != '0;
      r_cre_ret.count <= r_occ + w_disp_cnt;
    end else begin
      r_in_ptr        <= r_in_ptr + w_disp_cnt[PTR_W-1:0];
      r_out_ptr       <= r_out_ptr + w_free_cnt[PTR_W-1:0];
      r_occ           <= r_occ + w_disp_cnt - w_free_cnt;
      r_cre_ret.valid <= w_free_cnt != '0;
      r_cre_ret.count <= w_free_cnt;
    end
  end

  assign o_in_ptr  = r_in_ptr;
  assign o_out_ptr = r_out_ptr;
  assign o_cre_ret = r_cre_ret;

  // Dispatcher spent more credits than it was given
  a_no_overflow: assert property (@(posedge i_clk) disable iff (i_reset_n)
    !i_flush |-> ((r_occ + w_disp_cnt) <= CNT_W'(ENTRY_NUM)))
    else $error("sched_ring_ptr: overflow, occ=%h disp=%h", r_occ, w_disp_cnt);

  // Live entries are counted in occupancy, so none sits outside the span
  a_occ_covers_live: assert property (@(posedge i_clk) disable iff (i_reset_n)
    ((i_entry_valid & ~w_span_mask) == '0) && ($countones(i_entry_valid) <= r_occ))
    else $error("sched_ring_ptr: occ=%h live=%h", r_occ, i_entry_valid);

endmodule

`default_nettype wire

//--- rtl/sched_entry.sv
`timescale 1ns/1ps
`default_nettype none

module sched_entry
  import sched_pkg::*;
(
  input  logic                i_clk,
  input  logic                i_reset_n,

  input  logic                i_put,
  input  disp_t               i_put_data,

  input  wakeup_t             i_wakeup [WAKE_PORTS],

  input  logic                i_picked,
  input  logic                i_rs_conflict,
  input  logic                i_pipe_done,

  input  logic                i_flush,

  output logic                o_valid,
  output logic                o_ready,
  output logic                o_done,
  output issue_t              o_entry,
  output logic [CMT_ID_W-1:0] o_cmt_id
);

  sched_state_t r_state;
  disp_t        r_data;

  logic w_rs1_hit;
  logic w_rs2_hit;
  logic w_put_rs1_hit;
  logic w_put_rs2_hit;

  function automatic logic tag_hit(input logic [TAG_W-1:0] tag,
                                   input wakeup_t wk [WAKE_PORTS]);
    logic hit;
    hit = 1'b0;
    for (int p = 0; p < WAKE_PORTS; p++) begin
      hit = hit | (wk[p].valid & (wk[p].tag == tag));
    end
    return hit;
  endfunction

  // ----------------------------
  // Wakeup match
  // ----------------------------
  assign w_rs1_hit     = tag_hit(r_data.rs1_tag, i_wakeup);
  assign w_rs2_hit     = tag_hit(r_data.rs2_tag, i_wakeup);
  assign w_put_rs1_hit = tag_hit(i_put_data.rs1_tag, i_wakeup);  // Result landing at put
  assign w_put_rs2_hit = tag_hit(i_put_data.rs2_tag, i_wakeup);

  // ----------------------------
  // State machine
  // ----------------------------
  always_ff @(posedge i_clk) begin
    if (i_reset_n) begin
      r_state <= FREE;
    end else if (i_flush) begin
      r_state <= FREE;  // Kill whatever is here
    end else begin
      case (r_state)
        FREE: begin
          if (i_put) begin
            r_state <= WAIT;
          end
        end
        WAIT: begin
          if (i_picked) begin
            r_state <= ISSUED;
          end
        end
        ISSUED: begin
          if (i_rs_conflict) begin
            r_state <= WAIT;  // Read port lost, try again
          end else if (i_pipe_done) begin
            r_state <= DONE;
          end
        end
        DONE:    r_state <= FREE;
        default: r_state <= FREE;
      endcase
    end
  end

  // Payload and source readiness
  always_ff @(posedge i_clk) begin
    if (i_put) begin
      r_data           <= i_put_data;
      r_data.rs1_ready <= i_put_data.rs1_ready | w_put_rs1_hit;
      r_data.rs2_ready <= i_put_data.rs2_ready | w_put_rs2_hit;
    end else begin
      r_data.rs1_ready <= r_data.rs1_ready | w_rs1_hit;
      r_data.rs2_ready <= r_data.rs2_ready | w_rs2_hit;
    end
  end

  // ----------------------------
  // Outputs
  // ----------------------------
  assign o_valid = (r_state != FREE);
  assign o_ready = (r_state == WAIT) & r_data.rs1_ready & r_data.rs2_ready;
  assign o_done  = (r_state == DONE);

  assign o_entry.valid   = o_ready;
  assign o_entry.cmt_id  = r_data.cmt_id;
  assign o_entry.opcode  = r_data.opcode;
  assign o_entry.rd_tag  = r_data.rd_tag;
  assign o_entry.rs1_tag = r_data.rs1_tag;
  assign o_entry.rs2_tag = r_data.rs2_tag;
  assign o_cmt_id        = r_data.cmt_id;

  // Steering from the in pointer must never land on a live slot
  a_put_in_free: assert property (@(posedge i_clk) disable iff (i_reset_n)
    i_put |-> (r_state == FREE))
    else $error("sched_entry: put into busy slot, state=%h", r_state);

  // Pipe feedback names only ops it holds
  a_fb_in_issued: assert property (@(posedge i_clk) disable iff (i_reset_n)
    (i_rs_conflict || i_pipe_done) |-> (r_state == ISSUED))
    else $error("sched_entry: pipe feedback outside ISSUED, state=%h", r_state);

endmodule

`default_nettype wire

//--- rtl/sched_age_pick.sv
`timescale 1ns/1ps
`default_nettype none

module sched_age_pick
  import sched_pkg::*;
(
  input  logic [ENTRY_NUM-1:0] i_ready,
  input  logic [PTR_W-1:0]     i_out_ptr,
  output logic [ENTRY_NUM-1:0] o_pick_oh
);

  logic [2*ENTRY_NUM-1:0] w_ready_dbl;
  logic [2*ENTRY_NUM-1:0] w_rot_right;
  logic [ENTRY_NUM-1:0]   w_aged;      // Oldest slot at bit 0
  logic [ENTRY_NUM-1:0]   w_aged_lsb;
  logic [2*ENTRY_NUM-1:0] w_lsb_dbl;
  logic [2*ENTRY_NUM-1:0] w_rot_left;

  // ----------------------------
  // Rotate to age order
  // ----------------------------
  assign w_ready_dbl = {i_ready, i_ready};
  assign w_rot_right = w_ready_dbl >> i_out_ptr;
  assign w_aged      = w_rot_right[ENTRY_NUM-1:0];

  // Lowest set bit is the oldest ready op
  assign w_aged_lsb = w_aged & (~w_aged + 1'b1);

  // ----------------------------
  // Back to slot order
  // ----------------------------
  assign w_lsb_dbl  = {w_aged_lsb, w_aged_lsb};
  assign w_rot_left = w_lsb_dbl << i_out_ptr;
  assign o_pick_oh  = w_rot_left[2*ENTRY_NUM-1:ENTRY_NUM];

endmodule

`default_nettype wire

//--- rtl/sched_oh_mux.sv
`timescale 1ns/1ps
`default_nettype none

module sched_oh_mux #(
  parameter type T     = logic,
  parameter int  WORDS = 2
) (
  input  logic [WORDS-1:0] i_oh,
  input  T                 i_data [WORDS],
  output T                 o_selected
);

  always_comb begin
    o_selected = '0;
    for (int w = 0; w < WORDS; w++) begin
      if (i_oh[w]) begin
        o_selected = o_selected | i_data[w];  // OR of the selected words
      end
    end
  end

  // Two live selects would merge payloads
  always_comb begin
    a_sel_onehot0: assert final (!$isunknown(i_oh) -> $onehot0(i_oh))
      else $error("sched_oh_mux: select not one-hot, i_oh=%h", i_oh);
  end

endmodule

`default_nettype wire

//--- rtl/sched_pkg.sv
`default_nettype none

package sched_pkg;

  // ----------------------------
  // Sizes
  // ----------------------------
  localparam int ENTRY_NUM  = 8;
  localparam int DISP_PORTS = 2;
  localparam int WAKE_PORTS = 2;
  localparam int TAG_W      = 6;   // Physical register tag
  localparam int CMT_ID_W   = 5;
  localparam int PTR_W      = $clog2(ENTRY_NUM);
  localparam int CNT_W      = PTR_W + 1;  // Holds 0..ENTRY_NUM

  // ----------------------------
  // Entry state
  // ----------------------------
  typedef enum logic [1:0] {
    FREE,
    WAIT,     // Sources pending or ready to go
    ISSUED,   // In the pipe, may bounce back
    DONE      // One cycle, reports completion
  } sched_state_t;

  // ----------------------------
  // Payloads
  // ----------------------------

  // Op as it comes from the dispatcher
  typedef struct packed {
    logic [CMT_ID_W-1:0] cmt_id;
    logic [7:0]          opcode;
    logic [TAG_W-1:0]    rd_tag;
    logic [TAG_W-1:0]    rs1_tag;
    logic                rs1_ready;
    logic [TAG_W-1:0]    rs2_tag;
    logic                rs2_ready;
  } disp_t;

  // Op handed to the execution pipe
  typedef struct packed {
    logic                valid;
    logic [CMT_ID_W-1:0] cmt_id;
    logic [7:0]          opcode;
    logic [TAG_W-1:0]    rd_tag;
    logic [TAG_W-1:0]    rs1_tag;
    logic [TAG_W-1:0]    rs2_tag;
  } issue_t;

  typedef struct packed {
    logic             valid;
    logic [TAG_W-1:0] tag;
  } wakeup_t;

  typedef struct packed {
    logic                valid;
    logic [CMT_ID_W-1:0] cmt_id;
  } done_rpt_t;

  // Credits back to the dispatcher
  typedef struct packed {
    logic             valid;
    logic [CNT_W-1:0] count;
  } cre_ret_t;

endpackage

`default_nettype wire
